/* vldu_top.f */
+incdir+.
vldu_pkg.sv
vldu_insn_queue.sv
vldu_beat_packer.sv
vldu_result_queue.sv
vldu_top.sv
tb_vldu_top.sv

/* tb_vldu_table.svh */
// Eight rows of loads with ids 0 to 7, each id used once, and byte counts no larger than 64
`ifndef TB_VLDU_TABLE_SVH
`define TB_VLDU_TABLE_SVH

localparam int ROWS = 8;

// Instruction table with id, vd, vsew and vl
logic [2:0] tbl_id   [ROWS];
logic [4:0] tbl_vd   [ROWS];
logic [1:0] tbl_vsew [ROWS];
logic [6:0] tbl_vl   [ROWS];
// Words before each row, counted per lane
int         cum_words [ROWS+1];

task automatic set_row(input int n, input logic [2:0] id, input logic [4:0] vd,
                       input logic [1:0] vsew, input logic [6:0] vl);
  tbl_id[n]   = id;
  tbl_vd[n]   = vd;
  tbl_vsew[n] = vsew;
  tbl_vl[n]   = vl;
endtask

// Byte counts 8, 12, 16, 24, 40, 64, 5, 33
task automatic fill_table();
  set_row(0, 3'd0, 5'd1, 2'd0, 7'd8);
  set_row(1, 3'd1, 5'd2, 2'd2, 7'd3);
  set_row(2, 3'd2, 5'd3, 2'd1, 7'd8);
  set_row(3, 3'd3, 5'd4, 2'd3, 7'd3);
  set_row(4, 3'd4, 5'd5, 2'd2, 7'd10);
  set_row(5, 3'd5, 5'd6, 2'd3, 7'd8);
  set_row(6, 3'd6, 5'd7, 2'd0, 7'd5);
  set_row(7, 3'd7, 5'd8, 2'd0, 7'd33);
  cum_words[0] = 0;
  for (int n = 0; n < ROWS; n++) begin
    cum_words[n+1] = cum_words[n] + row_words(n);
  end
endtask

// Bytes of a row are vl times the element size
function automatic int row_bytes(input int n);
  return int'(tbl_vl[n]) * (1 << tbl_vsew[n]);
endfunction

function automatic int row_words(input int n);
  return (row_bytes(n) + 15) / 16;
endfunction

function automatic int row_beats(input int n);
  return (row_bytes(n) + 7) / 8;
endfunction

// Data rule for byte k of row n
function automatic logic [7:0] exp_byte(input int n, input int k);
  return 8'((n * 64 + k) % 256);
endfunction

// R beat b of row n takes byte j from k = b*8 + j
function automatic logic [63:0] beat_data(input int n, input int b);
  logic [63:0] d;
  for (int j = 0; j < 8; j++) begin
    d[8*j +: 8] = exp_byte(n, b * 8 + j);
  end
  return d;
endfunction

// Word byte b sits on lane b/8 at offset b%8
function automatic logic [7:0] exp_be(input int n, input int w, input int l);
  logic [7:0] be;
  for (int o = 0; o < 8; o++) begin
    be[o] = (w * 16 + l * 8 + o) < row_bytes(n);
  end
  return be;
endfunction

function automatic logic [63:0] exp_wdata(input int n, input int w, input int l);
  logic [63:0] d;
  for (int o = 0; o < 8; o++) begin
    d[8*o +: 8] = exp_byte(n, w * 16 + l * 8 + o);
  end
  return d;
endfunction

// Eight bits per enabled byte keep the compare to written bytes
function automatic logic [63:0] byte_mask(input logic [7:0] be);
  logic [63:0] m;
  for (int o = 0; o < 8; o++) begin
    m[8*o +: 8] = {8{be[o]}};
  end
  return m;
endfunction

`endif

/* tb_vldu_top.sv */
// Needs tb_vldu_table.svh on the include path; grants are held off for 30 cycles after reset
`timescale 1ns/1ns

module tb_vldu_top;

  logic        clk_i, rst_ni;
  logic        req_valid_i, req_ready_o;
  logic [2:0]  req_id_i;
  logic [4:0]  req_vd_i;
  logic [1:0]  req_vsew_i;
  logic [6:0]  req_vl_i;
  logic        r_valid_i, r_ready_o;
  logic [63:0] r_data_i;
  logic [1:0]        res_req_o, res_gnt_i;
  logic [1:0][2:0]   res_id_o;
  logic [1:0][6:0]   res_addr_o;
  logic [1:0][63:0]  res_wdata_o;
  logic [1:0][7:0]   res_be_o;
  logic [7:0]  vinsn_done_o;
  logic        load_complete_o;

  `include "tb_vldu_table.svh"

  localparam int TIMEOUT = 200 * ROWS;

  int errors, cycles, accepted, done_row, beat_row, beat_idx;
  int lane_row [2];
  int lane_w   [2];
  int lane_cnt [2];
  logic        hold;
  logic [7:0]  pending_done;
  // Payload of a request left waiting at the last edge
  logic        held [2];
  logic [81:0] held_pay [2];

  vldu_top dut0 (.*);

  always #10 clk_i = ~clk_i;

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act);
      errors++;
    end
  endtask

  // Compare one granted lane word against the next expected one
  task automatic score(input int l);
    int n;
    int w;
    logic [7:0] be;
    n = lane_row[l];
    w = lane_w[l];
    if (n >= ROWS) begin
      $display("Lane %0d was granted a word after the last instruction at time %0t", l, $time);
      errors++;
    end else begin
      be = exp_be(n, w, l);
      check_val($sformatf("res_id_o[%0d]", l), tbl_id[n], res_id_o[l]);
      check_val($sformatf("res_addr_o[%0d]", l), tbl_vd[n] * 4 + w, res_addr_o[l]);
      check_val($sformatf("res_be_o[%0d]", l), be, res_be_o[l]);
      check_val($sformatf("res_wdata_o[%0d]", l), exp_wdata(n, w, l) & byte_mask(be),
                res_wdata_o[l] & byte_mask(be));
      lane_w[l]++;
      lane_cnt[l]++;
      if (lane_w[l] == row_words(n)) begin
        lane_w[l] = 0;
        lane_row[l]++;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Lane grant model, R channel model and scoreboard
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (rst_ni) begin
      cycles++;
      if (cycles >= TIMEOUT) begin
        $display("Timeout after %0d cycles with %0d of %0d loads done", cycles, done_row, ROWS);
        $display("Verification failed");
        $finish;
      end else begin
        // Done pulses follow the retiring grant by one cycle and come in row order
        check_val("vinsn_done_o", pending_done, vinsn_done_o);
        check_val("load_complete_o", |pending_done, load_complete_o);
        pending_done = '0;
        for (int l = 0; l < 2; l++) begin
          // A waiting request keeps its payload
          if (held[l] && (!res_req_o[l] ||
              held_pay[l] != {res_id_o[l], res_addr_o[l], res_wdata_o[l], res_be_o[l]})) begin
            $display("Lane %0d request changed before its grant at time %0t", l, $time);
            errors++;
          end
          if (res_req_o[l] && res_gnt_i[l]) begin
            score(l);
          end
          held[l]     = res_req_o[l] && !res_gnt_i[l];
          held_pay[l] = {res_id_o[l], res_addr_o[l], res_wdata_o[l], res_be_o[l]};
        end
        if (done_row < ROWS && lane_cnt[0] >= cum_words[done_row+1] &&
            lane_cnt[1] >= cum_words[done_row+1]) begin
          pending_done = 8'(1) << tbl_id[done_row];
          done_row++;
        end
        // Beats follow the rows in order
        if (r_valid_i && r_ready_o) begin
          beat_idx++;
          if (beat_idx == row_beats(beat_row)) begin
            beat_idx = 0;
            beat_row++;
          end
        end
        if (beat_row < ROWS) begin
          r_valid_i <= hold ? 1'b1 : (($urandom % 4) != 0);
          r_data_i  <= beat_data(beat_row, beat_idx);
        end else begin
          r_valid_i <= 1'b0;
        end
        res_gnt_i <= hold ? 2'b00 : 2'($urandom);
      end
    end
  end

  // Sequencer sends one row after the other
  initial begin
    wait (rst_ni);
    for (int n = 0; n < ROWS; n++) begin
      req_valid_i <= 1'b1;
      req_id_i    <= tbl_id[n];
      req_vd_i    <= tbl_vd[n];
      req_vsew_i  <= tbl_vsew[n];
      req_vl_i    <= tbl_vl[n];
      @(posedge clk_i);
      while (!req_ready_o) begin
        @(posedge clk_i);
      end
      accepted++;
    end
    req_valid_i <= 1'b0;
  end

  initial begin
    void'($urandom(80));
    fill_table();
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    hold        = 1'b1;
    req_valid_i = 1'b0;
    req_id_i    = '0;
    req_vd_i    = '0;
    req_vsew_i  = '0;
    req_vl_i    = '0;
    // First beat is already offered while reset holds the unit idle
    r_valid_i   = 1'b1;
    r_data_i    = beat_data(0, 0);
    res_gnt_i   = '0;
    pending_done = '0;
    for (int l = 0; l < 2; l++) begin
      lane_row[l] = 0;
      lane_w[l]   = 0;
      lane_cnt[l] = 0;
      held[l]     = 1'b0;
    end
    repeat (4) @(posedge clk_i);
    check_val("res_req_o", 0, res_req_o);
    check_val("r_ready_o", 0, r_ready_o);
    check_val("vinsn_done_o", 0, vinsn_done_o);
    check_val("load_complete_o", 0, load_complete_o);
    rst_ni <= 1'b1;
    // Withheld grants let two words fill the result queue and four loads fill the instruction queue
    repeat (30) @(posedge clk_i);
    check_val("r_ready_o", 0, r_ready_o);
    check_val("req_ready_o", 0, req_ready_o);
    check_val("accepted", 4, accepted);
    hold <= 1'b0;
    while (done_row < ROWS) begin
      @(posedge clk_i);
    end
    repeat (4) @(posedge clk_i);
    check_val("res_req_o", 0, res_req_o);
    check_val("lane 0 words", cum_words[ROWS], lane_cnt[0]);
    check_val("lane 1 words", cum_words[ROWS], lane_cnt[1]);
    $display("Run over: %0d errors, %0d loads done, %0d cycles", errors, done_row, cycles);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* vldu_top.sv */
// Load path only without address generator, masks or shuffle, and the sequencer must never send vl of zero
`timescale 1ns/1ns

module vldu_top (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // Sequencer request
  input  logic                                         req_valid_i,
  input  vldu_pkg::vid_t                               req_id_i,
  input  vldu_pkg::vreg_t                              req_vd_i,
  input  vldu_pkg::vsew_t                              req_vsew_i,
  input  vldu_pkg::vl_t                                req_vl_i,
  output logic                                         req_ready_o,
  // Memory R channel
  input  logic                                         r_valid_i,
  input  vldu_pkg::beat_data_t                         r_data_i,
  output logic                                         r_ready_o,
  // Lane write-back
  output logic                 [vldu_pkg::NrLanes-1:0] res_req_o,
  output vldu_pkg::vid_t       [vldu_pkg::NrLanes-1:0] res_id_o,
  output vldu_pkg::vaddr_t     [vldu_pkg::NrLanes-1:0] res_addr_o,
  output vldu_pkg::lane_data_t [vldu_pkg::NrLanes-1:0] res_wdata_o,
  output vldu_pkg::lane_be_t   [vldu_pkg::NrLanes-1:0] res_be_o,
  input  logic                 [vldu_pkg::NrLanes-1:0] res_gnt_i,
  // Completion towards the sequencer
  output vldu_pkg::vinsn_done_t                        vinsn_done_o,
  output logic                                         load_complete_o
);

  //////////////////////////////////////////////////////////////////////
  // Stage links
  //////////////////////////////////////////////////////////////////////

  // Issue head and its completion
  logic               issue_valid, issue_done;
  vldu_pkg::vid_t     issue_id;
  vldu_pkg::vreg_t    issue_vd;
  vldu_pkg::bytecnt_t issue_bytes;

  // Packed word towards the result queue
  logic                                         push, rq_full, word_retired;
  vldu_pkg::vid_t                               push_id;
  vldu_pkg::vaddr_t                             push_addr;
  vldu_pkg::lane_data_t [vldu_pkg::NrLanes-1:0] push_wdata;
  vldu_pkg::lane_be_t   [vldu_pkg::NrLanes-1:0] push_be;

  // Input side
  vldu_insn_queue i_insn_queue (
    .clk_i, .rst_ni,
    .req_valid_i, .req_id_i, .req_vd_i, .req_vsew_i, .req_vl_i, .req_ready_o,
    .issue_valid_o   (issue_valid),
    .issue_id_o      (issue_id),
    .issue_vd_o      (issue_vd),
    .issue_bytes_o   (issue_bytes),
    .issue_done_i    (issue_done),
    .word_retired_i  (word_retired),
    .vinsn_done_o, .load_complete_o
  );

  // Processing part
  vldu_beat_packer i_beat_packer (
    .clk_i, .rst_ni,
    .r_valid_i, .r_data_i, .r_ready_o,
    .issue_valid_i (issue_valid),
    .issue_id_i    (issue_id),
    .issue_vd_i    (issue_vd),
    .issue_bytes_i (issue_bytes),
    .issue_done_o  (issue_done),
    .rq_full_i     (rq_full),
    .push_o        (push),
    .push_id_o     (push_id),
    .push_addr_o   (push_addr),
    .push_wdata_o  (push_wdata),
    .push_be_o     (push_be)
  );

  // Output side
  vldu_result_queue i_result_queue (
    .clk_i, .rst_ni,
    .push_i         (push),
    .push_id_i      (push_id),
    .push_addr_i    (push_addr),
    .push_wdata_i   (push_wdata),
    .push_be_i      (push_be),
    .rq_full_o      (rq_full),
    .word_retired_o (word_retired),
    .res_req_o, .res_id_o, .res_addr_o, .res_wdata_o, .res_be_o, .res_gnt_i
  );

endmodule

/* vldu_result_queue.sv */
// A word retires as soon as every lane has granted it; there is no final-grant wait
`timescale 1ns/1ns

module vldu_result_queue (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // Push side from the beat packer
  input  logic                                         push_i,
  input  vldu_pkg::vid_t                               push_id_i,
  input  vldu_pkg::vaddr_t                             push_addr_i,
  input  vldu_pkg::lane_data_t [vldu_pkg::NrLanes-1:0] push_wdata_i,
  input  vldu_pkg::lane_be_t   [vldu_pkg::NrLanes-1:0] push_be_i,
  output logic                                         rq_full_o,
  // Retirement towards the instruction queue
  output logic                                         word_retired_o,
  // Lane write-back
  output logic                 [vldu_pkg::NrLanes-1:0] res_req_o,
  output vldu_pkg::vid_t       [vldu_pkg::NrLanes-1:0] res_id_o,
  output vldu_pkg::vaddr_t     [vldu_pkg::NrLanes-1:0] res_addr_o,
  output vldu_pkg::lane_data_t [vldu_pkg::NrLanes-1:0] res_wdata_o,
  output vldu_pkg::lane_be_t   [vldu_pkg::NrLanes-1:0] res_be_o,
  input  logic                 [vldu_pkg::NrLanes-1:0] res_gnt_i
);

  // Entry payload with id and address shared across lanes
  vldu_pkg::vid_t   id_q   [vldu_pkg::ResultQueueDepth];
  vldu_pkg::vaddr_t addr_q [vldu_pkg::ResultQueueDepth];
  vldu_pkg::lane_data_t [vldu_pkg::NrLanes-1:0] wdata_q [vldu_pkg::ResultQueueDepth];
  vldu_pkg::lane_be_t   [vldu_pkg::NrLanes-1:0] be_q    [vldu_pkg::ResultQueueDepth];

  // Lanes still waiting to take each entry
  logic [vldu_pkg::NrLanes-1:0] valid_q [vldu_pkg::ResultQueueDepth];
  logic [vldu_pkg::NrLanes-1:0] valid_d [vldu_pkg::ResultQueueDepth];

  vldu_pkg::rq_pnt_t wr_pnt_q, rd_pnt_q;
  vldu_pkg::rq_cnt_t cnt_q;

  logic empty;

  assign rq_full_o = (cnt_q == vldu_pkg::rq_cnt_t'(vldu_pkg::ResultQueueDepth));
  assign empty     = (cnt_q == '0);

  //////////////////////////////////////////////////////////////////////
  // Lane write-back from the head entry
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int unsigned l = 0; l < vldu_pkg::NrLanes; l++) begin
      res_req_o[l]   = valid_q[rd_pnt_q][l];
      res_id_o[l]    = id_q[rd_pnt_q];
      res_addr_o[l]  = addr_q[rd_pnt_q];
      res_wdata_o[l] = wdata_q[rd_pnt_q][l];
      res_be_o[l]    = be_q[rd_pnt_q][l];
    end
  end

  // Head leaves once no lane is left waiting after this cycle's grants
  assign word_retired_o = !empty && ((valid_q[rd_pnt_q] & ~res_gnt_i) == '0);

  always_comb begin
    valid_d = valid_q;
    // A grant drops only that lane's request
    valid_d[rd_pnt_q] = valid_q[rd_pnt_q] & ~res_gnt_i;
    // Push never hits the head while it still holds requests
    if (push_i) begin
      valid_d[wr_pnt_q] = '1;
    end
  end

  // Entry payload written on push
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      id_q[wr_pnt_q]    <= push_id_i;
      addr_q[wr_pnt_q]  <= push_addr_i;
      wdata_q[wr_pnt_q] <= push_wdata_i;
      be_q[wr_pnt_q]    <= push_be_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned e = 0; e < vldu_pkg::ResultQueueDepth; e++) begin
        valid_q[e] <= '0;
      end
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      valid_q <= valid_d;
      if (push_i) begin
        wr_pnt_q <= wr_pnt_q + vldu_pkg::rq_pnt_t'(1);
      end
      if (word_retired_o) begin
        rd_pnt_q <= rd_pnt_q + vldu_pkg::rq_pnt_t'(1);
      end
      cnt_q <= cnt_q + vldu_pkg::rq_cnt_t'(push_i) - vldu_pkg::rq_cnt_t'(word_retired_o);
    end
  end

endmodule

/* vldu_beat_packer.sv */
// Every R beat is fully valid from byte 0 and bytes land sequentially on the lanes, with no shuffle or mask
`timescale 1ns/1ns

module vldu_beat_packer (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // Memory R channel
  input  logic                                         r_valid_i,
  input  vldu_pkg::beat_data_t                         r_data_i,
  output logic                                         r_ready_o,
  // Issue head from the instruction queue
  input  logic                                         issue_valid_i,
  input  vldu_pkg::vid_t                               issue_id_i,
  input  vldu_pkg::vreg_t                              issue_vd_i,
  input  vldu_pkg::bytecnt_t                           issue_bytes_i,
  output logic                                         issue_done_o,
  // Word push into the result queue
  input  logic                                         rq_full_i,
  output logic                                         push_o,
  output vldu_pkg::vid_t                               push_id_o,
  output vldu_pkg::vaddr_t                             push_addr_o,
  output vldu_pkg::lane_data_t [vldu_pkg::NrLanes-1:0] push_wdata_o,
  output vldu_pkg::lane_be_t   [vldu_pkg::NrLanes-1:0] push_be_o
);

  // Remaining bytes of the issue head where zero means not loaded yet
  vldu_pkg::bytecnt_t rem_q, rem_cur, rem_next, take;
  // Next free byte in the word being assembled
  vldu_pkg::fill_t    fill_q, fill_next;
  // Index of the word inside the instruction
  vldu_pkg::widx_t    widx_q;
  // Word assembly register
  vldu_pkg::lane_data_t [vldu_pkg::NrLanes-1:0] word_q, word_d;

  logic word_full, word_end;

  // Consume a beat only with an instruction to pack into and room downstream
  assign r_ready_o = r_valid_i && issue_valid_i && !rq_full_i;

  // A zero count marks a fresh instruction since vl is never zero
  assign rem_cur  = (rem_q == '0) ? issue_bytes_i : rem_q;
  assign take     = (rem_cur > vldu_pkg::bytecnt_t'(vldu_pkg::BeatBytes)) ?
                    vldu_pkg::bytecnt_t'(vldu_pkg::BeatBytes) : rem_cur;
  assign rem_next = rem_cur - take;

  assign fill_next = fill_q + vldu_pkg::fill_t'(take);
  assign word_full = (fill_next == vldu_pkg::fill_t'(vldu_pkg::WordBytes));
  assign word_end  = (rem_next == '0);

  //////////////////////////////////////////////////////////////////////
  // Byte placement
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    int unsigned b;
    // A new word starts clean so unwritten bytes read as zero
    word_d = (fill_q == '0) ? '0 : word_q;
    b      = 0;
    for (int unsigned j = 0; j < vldu_pkg::BeatBytes; j++) begin
      b = fill_q + j;
      // Bytes past the instruction end are dropped
      if ((j < take) && (b < vldu_pkg::WordBytes)) begin
        word_d[b / vldu_pkg::LaneBytes][8*(b % vldu_pkg::LaneBytes) +: 8] = r_data_i[8*j +: 8];
      end
    end
  end

  // Enables cover the bytes written so far as a prefix of the word
  always_comb begin
    for (int unsigned l = 0; l < vldu_pkg::NrLanes; l++) begin
      for (int unsigned o = 0; o < vldu_pkg::LaneBytes; o++) begin
        push_be_o[l][o] = ((l * vldu_pkg::LaneBytes + o) < fill_next);
      end
    end
  end

  // Push on the same edge as the beat that completes the word
  assign push_o       = r_ready_o && (word_full || word_end);
  assign push_id_o    = issue_id_i;
  assign push_addr_o  = vldu_pkg::vaddr_t'(issue_vd_i * vldu_pkg::VregWords + widx_q);
  assign push_wdata_o = word_d;
  assign issue_done_o = r_ready_o && word_end;

  // Word assembly data
  always_ff @(posedge clk_i) begin
    if (r_ready_o) begin
      word_q <= word_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rem_q  <= '0;
      fill_q <= '0;
      widx_q <= '0;
    end else if (r_ready_o) begin
      rem_q <= rem_next;
      if (push_o) begin
        fill_q <= '0;
        // Restart the word index for the next instruction
        widx_q <= word_end ? '0 : widx_q + vldu_pkg::widx_t'(1);
      end else begin
        fill_q <= fill_next;
      end
    end
  end

endmodule

/* vldu_insn_queue.sv */
// Every request is taken as a load for this unit; vl of zero is not allowed and ids must be unique in flight
`timescale 1ns/1ns

module vldu_insn_queue (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Sequencer request
  input  logic                  req_valid_i,
  input  vldu_pkg::vid_t        req_id_i,
  input  vldu_pkg::vreg_t       req_vd_i,
  input  vldu_pkg::vsew_t       req_vsew_i,
  input  vldu_pkg::vl_t         req_vl_i,
  output logic                  req_ready_o,
  // Issue head towards the beat packer
  output logic                  issue_valid_o,
  output vldu_pkg::vid_t        issue_id_o,
  output vldu_pkg::vreg_t       issue_vd_o,
  output vldu_pkg::bytecnt_t    issue_bytes_o,
  input  logic                  issue_done_i,
  // Word write-back from the result queue
  input  logic                  word_retired_i,
  // Completion towards the sequencer
  output vldu_pkg::vinsn_done_t vinsn_done_o,
  output logic                  load_complete_o
);

  // Entry storage
  vldu_pkg::vid_t     id_q    [vldu_pkg::InsnQueueDepth];
  vldu_pkg::vreg_t    vd_q    [vldu_pkg::InsnQueueDepth];
  vldu_pkg::bytecnt_t bytes_q [vldu_pkg::InsnQueueDepth];

  // Phase pointers and counts
  vldu_pkg::iq_pnt_t accept_pnt_q, issue_pnt_q, commit_pnt_q, commit_next;
  vldu_pkg::iq_cnt_t issue_cnt_q, issue_cnt_d;
  vldu_pkg::iq_cnt_t commit_cnt_q, commit_cnt_d;

  // Bytes still to be written back for the commit head
  vldu_pkg::bytecnt_t commit_bytes_q, commit_bytes_d, commit_left;

  vldu_pkg::bytecnt_t    req_bytes;
  vldu_pkg::vinsn_done_t done_d;
  logic                  accept, commit_valid, commit_pop;

  // Full once every slot waits for commit
  assign req_ready_o = (commit_cnt_q != vldu_pkg::iq_cnt_t'(vldu_pkg::InsnQueueDepth));
  assign accept      = req_valid_i && req_ready_o;
  assign req_bytes   = vldu_pkg::bytecnt_t'(req_vl_i) << req_vsew_i;

  // Issue head
  assign issue_valid_o = (issue_cnt_q != '0);
  assign issue_id_o    = id_q[issue_pnt_q];
  assign issue_vd_o    = vd_q[issue_pnt_q];
  assign issue_bytes_o = bytes_q[issue_pnt_q];

  //////////////////////////////////////////////////////////////////////
  // Commit side
  //////////////////////////////////////////////////////////////////////

  assign commit_valid = (commit_cnt_q != '0);
  assign commit_next  = commit_pnt_q + vldu_pkg::iq_pnt_t'(1);
  // Saturating decrement by one register-file word
  assign commit_left  = (commit_bytes_q > vldu_pkg::bytecnt_t'(vldu_pkg::WordBytes)) ?
                        commit_bytes_q - vldu_pkg::bytecnt_t'(vldu_pkg::WordBytes) : '0;
  assign commit_pop   = commit_valid && word_retired_i && (commit_left == '0);

  always_comb begin
    issue_cnt_d    = issue_cnt_q + vldu_pkg::iq_cnt_t'(accept)
                     - vldu_pkg::iq_cnt_t'(issue_done_i);
    commit_cnt_d   = commit_cnt_q + vldu_pkg::iq_cnt_t'(accept)
                     - vldu_pkg::iq_cnt_t'(commit_pop);
    commit_bytes_d = commit_bytes_q;
    done_d         = '0;

    if (word_retired_i) begin
      commit_bytes_d = commit_left;
    end
    // Finished head hands over to the byte count of the next stored one
    if (commit_pop) begin
      done_d[id_q[commit_pnt_q]] = 1'b1;
      if (commit_cnt_q > vldu_pkg::iq_cnt_t'(1)) begin
        commit_bytes_d = bytes_q[commit_next];
      end
    end
    // New instruction lands on an empty commit side
    if (accept && (commit_cnt_q - vldu_pkg::iq_cnt_t'(commit_pop) == '0)) begin
      commit_bytes_d = req_bytes;
    end
  end

  // Entry payload written on accept
  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_q[accept_pnt_q]    <= req_id_i;
      vd_q[accept_pnt_q]    <= req_vd_i;
      bytes_q[accept_pnt_q] <= req_bytes;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q    <= '0;
      issue_pnt_q     <= '0;
      commit_pnt_q    <= '0;
      issue_cnt_q     <= '0;
      commit_cnt_q    <= '0;
      commit_bytes_q  <= '0;
      vinsn_done_o    <= '0;
      load_complete_o <= 1'b0;
    end else begin
      if (accept) begin
        accept_pnt_q <= accept_pnt_q + vldu_pkg::iq_pnt_t'(1);
      end
      if (issue_done_i) begin
        issue_pnt_q <= issue_pnt_q + vldu_pkg::iq_pnt_t'(1);
      end
      if (commit_pop) begin
        commit_pnt_q <= commit_next;
      end
      issue_cnt_q     <= issue_cnt_d;
      commit_cnt_q    <= commit_cnt_d;
      commit_bytes_q  <= commit_bytes_d;
      // One-cycle pulses that follow the last retiring grant by one cycle
      vinsn_done_o    <= done_d;
      load_complete_o <= commit_pop;
    end
  end

endmodule

/* vldu_pkg.sv */
// Sizes are fixed for two 64-bit lanes and 64-bit R beats, and both queue depths must be powers of two
package vldu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  // Lanes and the width of one lane word
  localparam int unsigned NrLanes   = 2;
  localparam int unsigned LaneBytes = 8;
  // A register-file word spans all lanes
  localparam int unsigned WordBytes = NrLanes * LaneBytes;
  // Width of one R beat
  localparam int unsigned BeatBytes = 8;

  // Queue depths
  localparam int unsigned InsnQueueDepth   = 4;
  localparam int unsigned ResultQueueDepth = 2;

  // Lane words per vector register in each lane
  localparam int unsigned VregWords = 4;

  // Largest instruction is vl shifted left by vsew
  localparam int unsigned MaxInsnBytes = 64;
  localparam int unsigned MaxInsnWords = MaxInsnBytes / WordBytes;

  //////////////////////////////////////////////////////////////////////
  // Field types
  //////////////////////////////////////////////////////////////////////

  typedef logic [2:0] vid_t;
  typedef logic [4:0] vreg_t;
  // Codes 0 to 3 select 1, 2, 4 or 8 byte elements
  typedef logic [1:0] vsew_t;
  typedef logic [6:0] vl_t;
  typedef logic [6:0] bytecnt_t;
  typedef logic [6:0] vaddr_t;

  typedef logic [8*LaneBytes-1:0] lane_data_t;
  typedef logic [LaneBytes-1:0]   lane_be_t;
  typedef logic [8*BeatBytes-1:0] beat_data_t;
  // One bit per instruction id
  typedef logic [7:0]             vinsn_done_t;

  // Queue pointers and occupancy counts
  typedef logic [$clog2(InsnQueueDepth)-1:0]   iq_pnt_t;
  typedef logic [$clog2(InsnQueueDepth):0]     iq_cnt_t;
  typedef logic [$clog2(ResultQueueDepth)-1:0] rq_pnt_t;
  typedef logic [$clog2(ResultQueueDepth):0]   rq_cnt_t;

  // Byte fill pointer and word index inside one instruction
  typedef logic [$clog2(WordBytes):0]      fill_t;
  typedef logic [$clog2(MaxInsnWords)-1:0] widx_t;

endpackage
